// ==== include/lisp_consts.svh ====
`ifndef LISP_CONSTS_SVH
`define LISP_CONSTS_SVH

// Tagged memory word, the data field sits below a 4-bit tag
`define LISP_WORD_W 20
`define LISP_DATA_W 16

// Words of memory behind the single port
`define LISP_MEM_SIZE 8192

// Stack grows down from just below the top of memory
`define LISP_STACK_ORIGIN (`LISP_MEM_SIZE - 8)

// Opcode field width
`define LISP_OP_W 5

// Opcodes packed into one instruction word
`define LISP_SLOTS 4

`endif

// ==== logic/lisp_pkg.sv ====
`default_nettype none

`include "lisp_consts.svh"

package lisp_pkg;

	// Memory word with the tag in its upper bits
	typedef logic [`LISP_WORD_W-1:0] word_t;

	// Operand, result or stack address
	typedef logic [`LISP_DATA_W-1:0] data_t;

	// Word address with the 2-bit slot index below it
	typedef logic [`LISP_WORD_W+1:0] iptr_t;

	// Ops with both bits 4:3 set carry a parameter
	typedef enum logic [`LISP_OP_W-1:0] {
		OP_NOP = 5'd0,
		OP_POP = 5'd3,
		OP_LOAD = 5'd4,
		OP_STORE = 5'd5,
		OP_ADD = 5'd6,
		OP_SUB = 5'd7,
		OP_GTR = 5'd9,
		OP_GTE = 5'd10,
		OP_EQ = 5'd11,
		OP_NEQ = 5'd12,
		OP_DUP = 5'd13,
		OP_AND = 5'd16,
		OP_OR = 5'd17,
		OP_XOR = 5'd18,
		OP_PUSH = 5'd25,
		OP_GOTO = 5'd26,
		OP_BFALSE = 5'd27
	} opcode_t;

	typedef enum logic [2:0] {
		STATE_IADDR_ISSUE = 3'd0,
		STATE_DECODE = 3'd1,
		STATE_GOT_NOS = 3'd2,
		STATE_LOAD_TOS1 = 3'd3,
		STATE_PUSH_MEM_RESULT = 3'd4
	} seq_state_t;

	typedef enum logic [1:0] {
		SP_CURRENT = 2'd0,
		SP_DECREMENT = 2'd1,
		SP_INCREMENT = 2'd2
	} sp_sel_t;

	typedef enum logic [1:0] {
		TOS_CURRENT = 2'd0,
		TOS_PARAM = 2'd1,
		TOS_ALU_RESULT = 2'd2,
		TOS_MEMORY_RESULT = 2'd3
	} tos_sel_t;

	typedef enum logic [1:0] {
		MA_INSTRUCTION_POINTER = 2'd0,
		MA_STACK_POINTER = 2'd1,
		MA_TOP_OF_STACK = 2'd2,
		MA_STACK_POINTER_MINUS_ONE = 2'd3
	} ma_sel_t;

	typedef enum logic {
		MW_TOP_OF_STACK = 1'b0,
		MW_MEM_READ_VALUE = 1'b1
	} mw_sel_t;

	typedef enum logic [1:0] {
		IP_CURRENT = 2'd0,
		IP_NEXT = 2'd1,
		IP_BRANCH_TARGET = 2'd2
	} ip_sel_t;

endpackage

`default_nettype wire

// ==== logic/instr_unpack.sv ====
`default_nettype none

module instr_unpack (
	input wire clk,
	input wire rst_n,
	input wire lisp_pkg::seq_state_t state,
	input wire lisp_pkg::word_t mem_read_value,
	input wire [1:0] slot,
	output lisp_pkg::opcode_t opcode,
	output lisp_pkg::data_t param
);
	import lisp_pkg::*;

	word_t latched_word;
	word_t cur_word;

	// The fetched word is on the read bus only during DECODE
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			latched_word <= '0;
		else if (state == STATE_DECODE)
			latched_word <= mem_read_value;
	end

	assign cur_word = (state == STATE_DECODE) ? mem_read_value : latched_word;

	// Whatever follows the opcode in the word is its parameter
	always_comb
	begin
		case (slot)
			2'd0:
			begin
				opcode = opcode_t'(cur_word[19:15]);
				param = {cur_word[14], cur_word[14:0]};
			end
			2'd1:
			begin
				opcode = opcode_t'(cur_word[14:10]);
				param = {{6{cur_word[9]}}, cur_word[9:0]};
			end
			2'd2:
			begin
				opcode = opcode_t'(cur_word[9:5]);
				param = {{11{cur_word[4]}}, cur_word[4:0]};
			end
			default:
			begin
				// Last slot leaves no room for a parameter
				opcode = opcode_t'(cur_word[4:0]);
				param = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== logic/stack_alu.sv ====
`default_nettype none

module stack_alu (
	input wire lisp_pkg::opcode_t alu_op,
	input wire lisp_pkg::data_t op0,
	input wire lisp_pkg::data_t op1,
	output lisp_pkg::data_t result
);
	import lisp_pkg::*;

	data_t diff;
	logic zero;
	logic negative;

	// Compares look only at the sign and zero of the difference
	assign diff = op0 - op1;
	assign zero = diff == '0;
	assign negative = diff[$bits(data_t)-1];

	always_comb
	begin
		case (alu_op)
			OP_ADD:
				result = op0 + op1;
			OP_SUB:
				result = diff;
			OP_AND:
				result = op0 & op1;
			OP_OR:
				result = op0 | op1;
			OP_XOR:
				result = op0 ^ op1;
			OP_GTR:
				result = data_t'(!negative && !zero);
			OP_GTE:
				result = data_t'(!negative);
			OP_EQ:
				result = data_t'(zero);
			OP_NEQ:
				result = data_t'(!zero);
			default:
				result = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== logic/stack_datapath.sv ====
`default_nettype none

`include "lisp_consts.svh"

module stack_datapath (
	input wire clk,
	input wire rst_n,
	input wire lisp_pkg::sp_sel_t sp_sel,
	input wire lisp_pkg::tos_sel_t tos_sel,
	input wire lisp_pkg::ma_sel_t ma_sel,
	input wire lisp_pkg::mw_sel_t mw_sel,
	input wire lisp_pkg::ip_sel_t ip_sel,
	input wire lisp_pkg::word_t mem_read_value,
	input wire lisp_pkg::opcode_t opcode,
	input wire lisp_pkg::data_t param,
	input wire lisp_pkg::data_t alu_result,
	output lisp_pkg::data_t memory_address,
	output lisp_pkg::word_t mem_write_value,
	output logic [1:0] slot,
	output logic tos_zero,
	output lisp_pkg::data_t alu_op0,
	output lisp_pkg::data_t alu_op1
);
	import lisp_pkg::*;

	iptr_t instruction_pointer;
	iptr_t ip_next;
	data_t stack_pointer;
	data_t sp_next;
	word_t top_of_stack;
	word_t tos_next;
	word_t ip_word;
	word_t param_word;
	logic has_param;

	assign ip_word = instruction_pointer[`LISP_WORD_W+1:2];

	// Sign of the parameter carries up through the tag bits
	assign param_word = {{(`LISP_WORD_W-`LISP_DATA_W){param[`LISP_DATA_W-1]}}, param};

	assign has_param = opcode[`LISP_OP_W-1 -: 2] == 2'b11;

	always_comb
	begin
		case (ip_sel)
			IP_NEXT:
			begin
				// Parameter used up the word, so go to the next one
				if (has_param)
					ip_next = {ip_word, 2'b00} + iptr_t'(`LISP_SLOTS);
				else
					ip_next = instruction_pointer + 1'b1;
			end
			IP_BRANCH_TARGET:
				ip_next = {ip_word + param_word, 2'b00};
			default:
				ip_next = instruction_pointer;
		endcase
	end

	always_comb
	begin
		case (sp_sel)
			SP_DECREMENT:
				sp_next = stack_pointer - 1'b1;
			SP_INCREMENT:
				sp_next = stack_pointer + 1'b1;
			default:
				sp_next = stack_pointer;
		endcase
	end

	always_comb
	begin
		case (tos_sel)
			TOS_PARAM:
				tos_next = param_word;
			// Tag of the old top survives an ALU op
			TOS_ALU_RESULT:
				tos_next = {top_of_stack[`LISP_WORD_W-1:`LISP_DATA_W], alu_result};
			TOS_MEMORY_RESULT:
				tos_next = mem_read_value;
			default:
				tos_next = top_of_stack;
		endcase
	end

	// Fetch address comes from the next pointer, so it is ready a cycle early
	always_comb
	begin
		case (ma_sel)
			MA_STACK_POINTER:
				memory_address = stack_pointer;
			MA_TOP_OF_STACK:
				memory_address = top_of_stack[`LISP_DATA_W-1:0];
			MA_STACK_POINTER_MINUS_ONE:
				memory_address = stack_pointer - 1'b1;
			default:
				memory_address = ip_next[`LISP_DATA_W+1:2];
		endcase
	end

	assign mem_write_value = (mw_sel == MW_MEM_READ_VALUE) ? mem_read_value : top_of_stack;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			// All ones so the first step lands on word 0
			instruction_pointer <= '1;
			stack_pointer <= data_t'(`LISP_STACK_ORIGIN);
			top_of_stack <= '0;
		end
		else
		begin
			instruction_pointer <= ip_next;
			stack_pointer <= sp_next;
			top_of_stack <= tos_next;
		end
	end

	assign slot = instruction_pointer[1:0];
	assign tos_zero = top_of_stack[`LISP_DATA_W-1:0] == '0;
	assign alu_op0 = top_of_stack[`LISP_DATA_W-1:0];
	assign alu_op1 = mem_read_value[`LISP_DATA_W-1:0];

endmodule

`default_nettype wire

// ==== logic/stack_sequencer.sv ====
`default_nettype none

module stack_sequencer (
	input wire clk,
	input wire rst_n,
	input wire lisp_pkg::opcode_t opcode,
	input wire tos_zero,
	output lisp_pkg::seq_state_t state,
	output lisp_pkg::sp_sel_t sp_sel,
	output lisp_pkg::tos_sel_t tos_sel,
	output lisp_pkg::ma_sel_t ma_sel,
	output lisp_pkg::mw_sel_t mw_sel,
	output lisp_pkg::ip_sel_t ip_sel,
	output lisp_pkg::opcode_t alu_op,
	output logic mem_write_enable
);
	import lisp_pkg::*;

	seq_state_t state_next;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			state <= STATE_IADDR_ISSUE;
		else
			state <= state_next;
	end

	// Address mux defaults to the fetch of the next instruction
	always_comb
	begin
		state_next = state;
		sp_sel = SP_CURRENT;
		tos_sel = TOS_CURRENT;
		ma_sel = MA_INSTRUCTION_POINTER;
		mw_sel = MW_TOP_OF_STACK;
		ip_sel = IP_CURRENT;
		alu_op = OP_NOP;
		mem_write_enable = 1'b0;

		case (state)
			STATE_IADDR_ISSUE:
			begin
				ip_sel = IP_NEXT;
				state_next = STATE_DECODE;
			end

			STATE_DECODE:
			begin
				case (opcode)
					OP_POP:
					begin
						ma_sel = MA_STACK_POINTER;
						sp_sel = SP_INCREMENT;
						state_next = STATE_PUSH_MEM_RESULT;
					end

					// Replaces the top of stack with what it points at
					OP_LOAD:
					begin
						ma_sel = MA_TOP_OF_STACK;
						state_next = STATE_PUSH_MEM_RESULT;
					end

					// Two operands, so read the NOS first
					OP_STORE,
					OP_ADD,
					OP_SUB,
					OP_GTR,
					OP_GTE,
					OP_EQ,
					OP_NEQ,
					OP_AND,
					OP_OR,
					OP_XOR:
					begin
						ma_sel = MA_STACK_POINTER;
						state_next = STATE_GOT_NOS;
					end

					// Spill the top of stack, DUP then keeps it as is
					OP_PUSH,
					OP_DUP:
					begin
						sp_sel = SP_DECREMENT;
						ma_sel = MA_STACK_POINTER_MINUS_ONE;
						mw_sel = MW_TOP_OF_STACK;
						mem_write_enable = 1'b1;
						if (opcode == OP_PUSH)
							tos_sel = TOS_PARAM;
						state_next = STATE_IADDR_ISSUE;
					end

					OP_GOTO:
					begin
						ip_sel = IP_BRANCH_TARGET;
						state_next = STATE_DECODE;
					end

					// Pop now, the branch is taken once the new top arrives
					OP_BFALSE:
					begin
						ma_sel = MA_STACK_POINTER;
						sp_sel = SP_INCREMENT;
						state_next = STATE_PUSH_MEM_RESULT;
					end

					// NOP and unknown codes
					default:
					begin
						ip_sel = IP_NEXT;
						state_next = STATE_DECODE;
					end
				endcase
			end

			STATE_GOT_NOS:
			begin
				sp_sel = SP_INCREMENT;
				if (opcode == OP_STORE)
				begin
					// NOS goes to the address held in the top of stack
					ma_sel = MA_TOP_OF_STACK;
					mw_sel = MW_MEM_READ_VALUE;
					mem_write_enable = 1'b1;
					state_next = STATE_LOAD_TOS1;
				end
				else
				begin
					alu_op = opcode;
					tos_sel = TOS_ALU_RESULT;
					ip_sel = IP_NEXT;
					state_next = STATE_DECODE;
				end
			end

			// Both STORE operands are gone, refill the top of stack
			STATE_LOAD_TOS1:
			begin
				ma_sel = MA_STACK_POINTER;
				sp_sel = SP_INCREMENT;
				state_next = STATE_PUSH_MEM_RESULT;
			end

			STATE_PUSH_MEM_RESULT:
			begin
				tos_sel = TOS_MEMORY_RESULT;
				// Top of stack still holds the value BFALSE tests
				if (opcode == OP_BFALSE && tos_zero)
					ip_sel = IP_BRANCH_TARGET;
				else
					ip_sel = IP_NEXT;
				state_next = STATE_DECODE;
			end

			default:
				state_next = STATE_IADDR_ISSUE;
		endcase
	end

endmodule

`default_nettype wire

// ==== logic/lisp_core.sv ====
`default_nettype none

module lisp_core (
	input wire clk,
	input wire rst_n,
	input wire lisp_pkg::word_t mem_read_value,
	output lisp_pkg::data_t memory_address,
	output lisp_pkg::word_t mem_write_value,
	output logic mem_write_enable
);
	import lisp_pkg::*;

	seq_state_t state;
	logic [1:0] slot;
	opcode_t opcode;
	data_t param;
	sp_sel_t sp_sel;
	tos_sel_t tos_sel;
	ma_sel_t ma_sel;
	mw_sel_t mw_sel;
	ip_sel_t ip_sel;
	opcode_t alu_op;
	data_t alu_op0;
	data_t alu_op1;
	data_t alu_result;
	logic tos_zero;

	instr_unpack unpack0 (
		.clk(clk),
		.rst_n(rst_n),
		.state(state),
		.mem_read_value(mem_read_value),
		.slot(slot),
		.opcode(opcode),
		.param(param)
	);

	stack_alu alu0 (
		.alu_op(alu_op),
		.op0(alu_op0),
		.op1(alu_op1),
		.result(alu_result)
	);

	stack_datapath datapath0 (
		.clk(clk),
		.rst_n(rst_n),
		.sp_sel(sp_sel),
		.tos_sel(tos_sel),
		.ma_sel(ma_sel),
		.mw_sel(mw_sel),
		.ip_sel(ip_sel),
		.mem_read_value(mem_read_value),
		.opcode(opcode),
		.param(param),
		.alu_result(alu_result),
		.memory_address(memory_address),
		.mem_write_value(mem_write_value),
		.slot(slot),
		.tos_zero(tos_zero),
		.alu_op0(alu_op0),
		.alu_op1(alu_op1)
	);

	stack_sequencer sequencer0 (
		.clk(clk),
		.rst_n(rst_n),
		.opcode(opcode),
		.tos_zero(tos_zero),
		.state(state),
		.sp_sel(sp_sel),
		.tos_sel(tos_sel),
		.ma_sel(ma_sel),
		.mw_sel(mw_sel),
		.ip_sel(ip_sel),
		.alu_op(alu_op),
		.mem_write_enable(mem_write_enable)
	);

endmodule

`default_nettype wire

// ==== bench/lisp_core_assertions.sv ====
`default_nettype none

module lisp_core_assertions (
	input wire clk,
	input wire rst_n,
	input wire lisp_pkg::seq_state_t state,
	input wire lisp_pkg::sp_sel_t sp_sel,
	input wire mem_write_enable
);
	timeunit 1ns;
	timeprecision 100ps;

	import lisp_pkg::*;

	// Count of failed assertions
	int failures = 0;

	state_known: assert property (@(posedge clk) disable iff (!rst_n)
		!$isunknown(state))
	else
	begin
		failures++;
		$error("sequencer state is unknown");
	end

	// Neither the fetch state nor the reload state may write memory
	no_write_in_fetch: assert property (@(posedge clk) disable iff (!rst_n)
		(state == STATE_IADDR_ISSUE || state == STATE_PUSH_MEM_RESULT) |-> !mem_write_enable)
	else
	begin
		failures++;
		$error("write strobe high in a fetch or reload state");
	end

	no_pop_in_fetch: assert property (@(posedge clk) disable iff (!rst_n)
		state == STATE_IADDR_ISSUE |-> sp_sel != SP_INCREMENT)
	else
	begin
		failures++;
		$error("stack pointer incremented during instruction fetch");
	end

endmodule

bind stack_sequencer lisp_core_assertions seq_checks (
	.clk(clk),
	.rst_n(rst_n),
	.state(state),
	.sp_sel(sp_sel),
	.mem_write_enable(mem_write_enable)
);

`default_nettype wire

// ==== bench/lisp_core_tb.sv ====
`default_nettype none

`include "lisp_consts.svh"

module lisp_core_tb;
	timeunit 1ns;
	timeprecision 100ps;

	import lisp_pkg::*;

	localparam int NUM_TESTS = 6;
	localparam int TEST_CYCLES = 300;

	logic clk;
	logic rst_n;
	word_t mem_read_value;
	data_t memory_address;
	word_t mem_write_value;
	logic mem_write_enable;

	word_t mem[`LISP_MEM_SIZE];
	word_t image[`LISP_MEM_SIZE];
	word_t ref_mem[`LISP_MEM_SIZE];

	data_t cap_addr = '0;
	word_t cap_value = '0;
	logic cap_we = 1'b0;

	data_t exp_addr[$];
	word_t exp_value[$];

	string cur_test;
	logic window_active;
	int errors;
	int tests_run;
	int tests_failed;
	int emit_ptr;
	data_t halt_addr;
	logic [31:0] lfsr_state;

	lisp_core dut0 (
		.clk(clk),
		.rst_n(rst_n),
		.mem_read_value(mem_read_value),
		.memory_address(memory_address),
		.mem_write_value(mem_write_value),
		.mem_write_enable(mem_write_enable)
	);

	initial
	begin
		clk = 1'b0;
	end

	always #4 clk = ~clk;

	task automatic check_value(input string what, input logic [19:0] exp, input logic [19:0] act);
		if (act !== exp)
		begin
			errors++;
			$display("ERR %s: %s expected %h actual %h", cur_test, what, exp, act);
		end
	endtask

	task automatic compare_write(input data_t addr, input word_t value);
		if (exp_addr.size() == 0)
		begin
			errors++;
			$display("%s: unexpected write of %h to address %h", cur_test, value, addr);
		end
		else
		begin
			check_value("write address", exp_addr.pop_front(), addr);
			check_value("write data", exp_value.pop_front(), value);
		end
	endtask

	// Outputs are stable at the falling edge
	always @(negedge clk)
	begin
		cap_addr = memory_address;
		cap_value = mem_write_value;
		cap_we = mem_write_enable;
	end

	// Registered read that returns old data on a same-cycle write
	always @(posedge clk)
	begin
		#1;
		mem_read_value = mem[cap_addr[12:0]];
		if (cap_we === 1'b1)
		begin
			mem[cap_addr[12:0]] = cap_value;
			if (window_active && cap_addr >= 16'd256 && cap_addr < 16'd512)
				compare_write(cap_addr, cap_value);
		end
	end

	function automatic logic take_bit();
		logic nb;
		nb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
		lfsr_state = {lfsr_state[30:0], nb};
		return nb;
	endfunction

	function automatic logic [14:0] rand15();
		logic [14:0] v;
		for (int i = 0; i < 15; i++)
			v[i] = take_bit();
		return v;
	endfunction

	// Compares are on signed values
	function automatic data_t alu_ref(input opcode_t op, input data_t a, input data_t b);
		case (op)
			OP_ADD: return a + b;
			OP_SUB: return a - b;
			OP_AND: return a & b;
			OP_OR: return a | b;
			OP_XOR: return a ^ b;
			OP_GTR: return data_t'($signed(a) > $signed(b));
			OP_GTE: return data_t'($signed(a) >= $signed(b));
			OP_EQ: return data_t'(a == b);
			OP_NEQ: return data_t'(a != b);
			default: return '0;
		endcase
	endfunction

	function automatic void ref_write(input data_t a, input word_t v);
		ref_mem[a[12:0]] = v;
		if (a >= 16'd256 && a < 16'd512)
		begin
			exp_addr.push_back(a);
			exp_value.push_back(v);
		end
	endfunction

	// Instruction-level interpreter that returns the step count or -1 if it never halts
	function automatic int interpret();
		data_t pc;
		logic [1:0] slot;
		data_t sp;
		word_t tos;
		word_t w;
		word_t pw;
		word_t nos;
		opcode_t op;
		int steps;
		logic done;
		logic jumped;
		for (int i = 0; i < `LISP_MEM_SIZE; i++)
			ref_mem[i] = image[i];
		exp_addr.delete();
		exp_value.delete();
		pc = '0;
		slot = 2'd0;
		sp = data_t'(`LISP_STACK_ORIGIN);
		tos = '0;
		steps = 0;
		done = 1'b0;
		while (!done && steps < 4000)
		begin
			w = ref_mem[pc[12:0]];
			jumped = 1'b0;
			steps++;
			case (slot)
				2'd0:
				begin
					op = opcode_t'(w[19:15]);
					pw = {{5{w[14]}}, w[14:0]};
				end
				2'd1:
				begin
					op = opcode_t'(w[14:10]);
					pw = {{10{w[9]}}, w[9:0]};
				end
				2'd2:
				begin
					op = opcode_t'(w[9:5]);
					pw = {{15{w[4]}}, w[4:0]};
				end
				default:
				begin
					op = opcode_t'(w[4:0]);
					pw = '0;
				end
			endcase
			case (op)
				OP_PUSH:
				begin
					sp--;
					ref_mem[sp[12:0]] = tos;
					tos = pw;
				end
				OP_DUP:
				begin
					sp--;
					ref_mem[sp[12:0]] = tos;
				end
				OP_POP:
				begin
					tos = ref_mem[sp[12:0]];
					sp++;
				end
				OP_LOAD:
					tos = ref_mem[tos[12:0]];
				OP_STORE:
				begin
					nos = ref_mem[sp[12:0]];
					sp++;
					ref_write(tos[15:0], nos);
					tos = ref_mem[sp[12:0]];
					sp++;
				end
				OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_GTR, OP_GTE, OP_EQ, OP_NEQ:
				begin
					nos = ref_mem[sp[12:0]];
					sp++;
					tos = {tos[19:16], alu_ref(op, tos[15:0], nos[15:0])};
				end
				OP_GOTO:
				begin
					// A jump to itself ends the program
					if (pw == '0)
						done = 1'b1;
					pc = pc + pw[15:0];
					slot = 2'd0;
					jumped = 1'b1;
				end
				OP_BFALSE:
				begin
					nos = ref_mem[sp[12:0]];
					sp++;
					if (tos[15:0] == '0)
					begin
						pc = pc + pw[15:0];
						slot = 2'd0;
						jumped = 1'b1;
					end
					tos = nos;
				end
				default:
				begin
				end
			endcase
			if (!jumped)
			begin
				if (op[4:3] == 2'b11)
				begin
					pc++;
					slot = 2'd0;
				end
				else
				begin
					slot++;
					if (slot == 2'd0)
						pc++;
				end
			end
		end
		return done ? steps : -1;
	endfunction

	function automatic word_t op_word(input opcode_t o0, input opcode_t o1,
		input opcode_t o2, input opcode_t o3);
		return {o0, o1, o2, o3};
	endfunction

	function automatic word_t param_word(input opcode_t o, input logic [14:0] p);
		return {o, p};
	endfunction

	task automatic start_program();
		for (int i = 0; i < `LISP_MEM_SIZE; i++)
			image[i] = word_t'((i * 7919) ^ 20'h5a5a5);
		emit_ptr = 0;
	endtask

	task automatic emit(input word_t w);
		image[emit_ptr] = w;
		emit_ptr++;
	endtask

	task automatic store_block(input logic [14:0] v, input logic [14:0] a);
		emit(param_word(OP_PUSH, v));
		emit(param_word(OP_PUSH, a));
		emit(op_word(OP_STORE, OP_NOP, OP_NOP, OP_NOP));
	endtask

	task automatic emit_halt();
		halt_addr = data_t'(emit_ptr);
		emit(param_word(OP_GOTO, 15'd0));
	endtask

	task automatic run_program(input string name);
		int start_errors;
		int cycles;
		int seen;
		int n;
		cur_test = name;
		start_errors = errors;
		@(posedge clk);
		#1;
		rst_n = 1'b0;
		window_active = 1'b0;
		for (int i = 0; i < `LISP_MEM_SIZE; i++)
			mem[i] = image[i];
		n = interpret();
		if (n < 0)
		begin
			errors++;
			$display("%s: reference interpreter never reached the final loop", name);
		end
		repeat (2)
		begin
			@(negedge clk);
			check_value("write enable in reset", 20'd0, mem_write_enable);
		end
		@(posedge clk);
		#1;
		rst_n = 1'b1;
		window_active = 1'b1;
		@(negedge clk);
		check_value("first fetch address", 20'd0, memory_address);
		check_value("write enable after reset", 20'd0, mem_write_enable);
		cycles = 0;
		seen = 0;
		// The final loop fetches its own word over and over
		while (seen < 2 && cycles < TEST_CYCLES)
		begin
			@(negedge clk);
			cycles++;
			if (memory_address == halt_addr)
				seen++;
			else
				seen = 0;
		end
		if (seen < 2)
		begin
			errors++;
			$display("%s: program did not reach its final loop in %0d cycles", name, TEST_CYCLES);
		end
		@(negedge clk);
		window_active = 1'b0;
		if (exp_addr.size() != 0)
		begin
			errors++;
			$display("%s: %0d expected data writes never happened", name, exp_addr.size());
		end
		tests_run++;
		if (errors == start_errors)
			$display("test %s: ok after %0d cycles", name, cycles);
		else
		begin
			tests_failed++;
			$display("test %s: failed with %0d errors", name, errors - start_errors);
		end
	endtask

	task automatic test_arith();
		opcode_t ops[5];
		ops = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR};
		start_program();
		for (int k = 0; k < 15; k++)
		begin
			emit(param_word(OP_PUSH, rand15()));
			emit(param_word(OP_PUSH, rand15()));
			emit(op_word(ops[k % 5], OP_NOP, OP_NOP, OP_NOP));
			emit(param_word(OP_PUSH, 15'(256 + k)));
			emit(op_word(OP_STORE, OP_NOP, OP_NOP, OP_NOP));
		end
		emit_halt();
		run_program("arith");
	endtask

	task automatic test_compare();
		opcode_t ops[4];
		logic [14:0] a;
		logic [14:0] b;
		ops = '{OP_GTR, OP_GTE, OP_EQ, OP_NEQ};
		start_program();
		for (int k = 0; k < 12; k++)
		begin
			a = rand15();
			// Equal, adjacent and random pairs
			case (k % 3)
				0: b = a;
				1: b = a + 15'd1;
				default: b = rand15();
			endcase
			emit(param_word(OP_PUSH, a));
			emit(param_word(OP_PUSH, b));
			emit(op_word(ops[k % 4], OP_NOP, OP_NOP, OP_NOP));
			emit(param_word(OP_PUSH, 15'(256 + k)));
			emit(op_word(OP_STORE, OP_NOP, OP_NOP, OP_NOP));
		end
		emit_halt();
		run_program("compare");
	endtask

	task automatic test_stack_mem();
		start_program();
		store_block(rand15(), 15'd300);
		emit(param_word(OP_PUSH, 15'd300));
		emit(op_word(OP_LOAD, OP_DUP, OP_ADD, OP_NOP));
		emit(param_word(OP_PUSH, 15'd301));
		emit(op_word(OP_STORE, OP_NOP, OP_NOP, OP_NOP));
		emit(param_word(OP_PUSH, rand15()));
		emit(param_word(OP_PUSH, 15'd5));
		emit(op_word(OP_POP, OP_NOP, OP_NOP, OP_NOP));
		emit(param_word(OP_PUSH, 15'd302));
		emit(op_word(OP_STORE, OP_NOP, OP_NOP, OP_NOP));
		emit_halt();
		run_program("stack_mem");
	endtask

	task automatic test_branch();
		start_program();
		// Zero on top, so the first marker is skipped
		emit(param_word(OP_PUSH, 15'd0));
		emit(param_word(OP_BFALSE, 15'd4));
		store_block(15'h111, 15'd400);
		store_block(15'h222, 15'd401);
		emit(param_word(OP_PUSH, 15'd5));
		emit(param_word(OP_BFALSE, 15'd4));
		store_block(15'h333, 15'd402);
		emit(param_word(OP_GOTO, 15'd4));
		store_block(15'h444, 15'd403);
		store_block(15'h555, 15'd404);
		emit_halt();
		run_program("branch");
	endtask

	task automatic test_packing();
		start_program();
		emit(param_word(OP_PUSH, rand15()));
		emit(param_word(OP_PUSH, rand15()));
		emit(param_word(OP_PUSH, rand15()));
		emit(op_word(OP_ADD, OP_XOR, OP_DUP, OP_ADD));
		emit(param_word(OP_PUSH, 15'd450));
		emit(op_word(OP_STORE, OP_NOP, OP_NOP, OP_NOP));
		// PUSH in the second slot with a negative 10-bit parameter
		emit({OP_DUP, OP_PUSH, 10'h2a5});
		emit(op_word(OP_SUB, OP_NOP, OP_NOP, OP_NOP));
		emit(param_word(OP_PUSH, 15'd451));
		emit(op_word(OP_STORE, OP_NOP, OP_NOP, OP_NOP));
		emit_halt();
		run_program("packing");
	endtask

	initial
	begin
		repeat (NUM_TESTS * TEST_CYCLES) @(posedge clk);
		$display("Watchdog expired before the tests finished");
		$display("*** TEST FAILED ***");
		$finish;
	end

	initial
	begin
		rst_n = 1'b0;
		mem_read_value = '0;
		window_active = 1'b0;
		lfsr_state = 32'h9978df78;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		halt_addr = '0;
		cur_test = "init";

		start_program();
		emit_halt();
		run_program("reset");
		test_arith();
		test_compare();
		test_stack_mem();
		test_branch();
		test_packing();

		$display("Summary: %0d tests, %0d failed, %0d errors, %0d assertion failures",
			tests_run, tests_failed, errors, dut0.sequencer0.seq_checks.failures);
		if (errors == 0 && tests_failed == 0 && dut0.sequencer0.seq_checks.failures == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+include
logic/lisp_pkg.sv
logic/instr_unpack.sv
logic/stack_alu.sv
logic/stack_datapath.sv
logic/stack_sequencer.sv
logic/lisp_core.sv
bench/lisp_core_assertions.sv
bench/lisp_core_tb.sv

// ==== Bender.yml ====
package:
  name: lisp_core

sources:
  - include_dirs:
      - include
    files:
      - logic/lisp_pkg.sv
      - logic/instr_unpack.sv
      - logic/stack_alu.sv
      - logic/stack_datapath.sv
      - logic/stack_sequencer.sv
      - logic/lisp_core.sv
  - target: test
    include_dirs:
      - include
    files:
      - bench/lisp_core_assertions.sv
      - bench/lisp_core_tb.sv
